//--- hw/riscv_types_pkg.sv
package riscv_types_pkg;

  // ------------------------------
  // Architectural widths
  // ------------------------------
  localparam int unsigned XLEN = 64;

  // Address or data word
  typedef logic [XLEN-1:0] xlen_t;
  // Uncompressed instruction word
  typedef logic [31:0]     insn_t;
  // Integer register index
  typedef logic [4:0]      reg_addr_t;

  // ------------------------------
  // Privilege levels
  // ------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // Step from one PC to the next, no compressed instructions here
  localparam xlen_t InsnBytes = xlen_t'(4);

endpackage

//--- hw/trace_pkg.sv
package trace_pkg;

  // ------------------------------
  // Commit port entry
  // ------------------------------
  typedef struct packed {
    riscv_types_pkg::xlen_t     pc;
    riscv_types_pkg::insn_t     insn;
    riscv_types_pkg::reg_addr_t rs1;
    riscv_types_pkg::reg_addr_t rs2;
    riscv_types_pkg::reg_addr_t rd;
    // Entry carries an exception
    logic                       ex_valid;
  } commit_entry_t;

  // Running count of retirements
  typedef logic [63:0] order_t;

  // ------------------------------
  // Retire record, RVFI style
  // ------------------------------
  typedef struct packed {
    order_t                     order;
    riscv_types_pkg::insn_t     insn;
    riscv_types_pkg::xlen_t     pc_rdata;
    riscv_types_pkg::xlen_t     pc_wdata;
    riscv_types_pkg::reg_addr_t rs1_addr;
    riscv_types_pkg::reg_addr_t rs2_addr;
    riscv_types_pkg::reg_addr_t rd_addr;
    riscv_types_pkg::priv_lvl_t mode;
  } retire_rec_t;

endpackage

//--- hw/pc_queue.sv
module pc_queue #(
  parameter int unsigned PcQueueDepth = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  riscv_types_pkg::xlen_t pc_i,
  input  logic                   pop_i,
  output logic                   empty_o,
  output riscv_types_pkg::xlen_t pc_o
);

  import riscv_types_pkg::*;

  localparam int unsigned PtrW = (PcQueueDepth > 1) ? $clog2(PcQueueDepth) : 1;
  localparam int unsigned CntW = $clog2(PcQueueDepth + 1);

  typedef logic [PtrW-1:0] ptr_t;
  typedef logic [CntW-1:0] cnt_t;

  xlen_t mem_q [PcQueueDepth];
  ptr_t  wr_ptr_q, rd_ptr_q;
  cnt_t  cnt_q;
  logic  full, do_push, do_pop;

  // Pointers wrap at the depth, which need not be a power of two
  function automatic ptr_t next_ptr(ptr_t ptr);
    if (ptr == ptr_t'(PcQueueDepth - 1)) begin
      return '0;
    end
    return ptr + ptr_t'(1);
  endfunction

  assign full    = (cnt_q == cnt_t'(PcQueueDepth));
  assign empty_o = (cnt_q == '0);
  assign pc_o    = mem_q[rd_ptr_q];

  // A push into a full buffer is lost
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + cnt_t'(1);
        2'b01:   cnt_q <= cnt_q - cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

endmodule

//--- hw/pc_rr_arbiter.sv
module pc_rr_arbiter #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                   [NrCommitPorts-1:0] empty_i,
  input  riscv_types_pkg::xlen_t [NrCommitPorts-1:0] pc_i,
  output logic                   [NrCommitPorts-1:0] pop_o,
  output logic                                       pc_valid_o,
  output riscv_types_pkg::xlen_t                     pc_o
);

  localparam int unsigned IdxW = (NrCommitPorts > 1) ? $clog2(NrCommitPorts) : 1;

  typedef logic [IdxW-1:0] idx_t;

  idx_t ptr_q;
  idx_t gnt_idx;
  logic gnt_found;

  // ------------------------------
  // Grant search from the pointer
  // ------------------------------
  always_comb begin
    int unsigned cand;
    gnt_found = 1'b0;
    gnt_idx   = ptr_q;
    for (int unsigned k = 0; k < NrCommitPorts; k++) begin
      cand = int'(ptr_q) + k;
      if (cand >= NrCommitPorts) begin
        cand = cand - NrCommitPorts;
      end
      if (!gnt_found && !empty_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = idx_t'(cand);
      end
    end
  end

  // Grant is the pop, no back-pressure on the stream
  always_comb begin
    pop_o          = '0;
    pop_o[gnt_idx] = gnt_found;
  end

  assign pc_valid_o = gnt_found;
  assign pc_o       = pc_i[gnt_idx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (gnt_found) begin
      ptr_q <= (gnt_idx == idx_t'(NrCommitPorts - 1)) ? '0 : gnt_idx + idx_t'(1);
    end
  end

endmodule

//--- hw/retire_reporter.sv
module retire_reporter #(
  parameter int unsigned NrCommitPorts = 2
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  trace_pkg::commit_entry_t [NrCommitPorts-1:0]      commit_entry_i,
  input  logic                     [NrCommitPorts-1:0]      commit_ack_i,
  input  riscv_types_pkg::priv_lvl_t                        priv_lvl_i,
  output logic                                              rvfi_valid_o,
  output trace_pkg::retire_rec_t                            rvfi_rec_o,
  output logic                                              rvfi_trap_o
);

  import riscv_types_pkg::*;
  import trace_pkg::*;

  retire_rec_t rec_d, rec_q;
  logic        valid_d, valid_q;
  logic        trap_d, trap_q;

  // ------------------------------
  // Port scan
  // ------------------------------
  always_comb begin
    rec_d   = rec_q;
    valid_d = 1'b0;
    trap_d  = 1'b0;
    // Later ports overwrite earlier ones, so the highest index wins
    for (int unsigned i = 0; i < NrCommitPorts; i++) begin
      if (commit_ack_i[i] && !commit_entry_i[i].ex_valid) begin
        valid_d        = 1'b1;
        rec_d.insn     = commit_entry_i[i].insn;
        rec_d.pc_rdata = commit_entry_i[i].pc;
        rec_d.pc_wdata = commit_entry_i[i].pc + InsnBytes;
        rec_d.rs1_addr = commit_entry_i[i].rs1;
        rec_d.rs2_addr = commit_entry_i[i].rs2;
        rec_d.rd_addr  = commit_entry_i[i].rd;
        rec_d.mode     = priv_lvl_i;
      end
      if (commit_ack_i[i] && commit_entry_i[i].ex_valid) begin
        trap_d = 1'b1;
      end
    end
    // One order step per record
    if (valid_d) begin
      rec_d.order = rec_q.order + order_t'(1);
    end
  end

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      trap_q  <= 1'b0;
      rec_q   <= '0;
    end else begin
      valid_q <= valid_d;
      trap_q  <= trap_d;
      rec_q   <= rec_d;
    end
  end

  assign rvfi_valid_o = valid_q;
  assign rvfi_trap_o  = trap_q;
  assign rvfi_rec_o   = rec_q;

endmodule

//--- hw/commit_trace.sv
module commit_trace #(
  parameter int unsigned NrCommitPorts = 2,
  parameter int unsigned PcQueueDepth  = 16
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  trace_pkg::commit_entry_t [NrCommitPorts-1:0] commit_entry_i,
  input  logic                     [NrCommitPorts-1:0] commit_ack_i,
  input  riscv_types_pkg::priv_lvl_t                   priv_lvl_i,
  output logic                                         rvfi_valid_o,
  output trace_pkg::retire_rec_t                       rvfi_rec_o,
  output logic                                         rvfi_trap_o,
  output logic                                         pc_valid_o,
  output riscv_types_pkg::xlen_t                       pc_o
);

  import riscv_types_pkg::*;

  logic  [NrCommitPorts-1:0] pc_push;
  logic  [NrCommitPorts-1:0] pc_pop;
  logic  [NrCommitPorts-1:0] pc_empty;
  xlen_t [NrCommitPorts-1:0] pc_head;

  // ------------------------------
  // Retire record
  // ------------------------------
  retire_reporter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_retire_reporter (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_entry_i ( commit_entry_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .priv_lvl_i     ( priv_lvl_i     ),
    .rvfi_valid_o   ( rvfi_valid_o   ),
    .rvfi_rec_o     ( rvfi_rec_o     ),
    .rvfi_trap_o    ( rvfi_trap_o    )
  );

  // ------------------------------
  // Per-port PC queues
  // ------------------------------
  for (genvar p = 0; p < NrCommitPorts; p++) begin : gen_pc_queue
    // Traps never enter the stream
    assign pc_push[p] = commit_ack_i[p] & ~commit_entry_i[p].ex_valid;

    pc_queue #(
      .PcQueueDepth ( PcQueueDepth )
    ) i_pc_queue (
      .clk_i   ( clk_i                ),
      .rst_ni  ( rst_ni               ),
      .push_i  ( pc_push[p]           ),
      .pc_i    ( commit_entry_i[p].pc ),
      .pop_i   ( pc_pop[p]            ),
      .empty_o ( pc_empty[p]          ),
      .pc_o    ( pc_head[p]           )
    );
  end

  // Merge into one stream
  pc_rr_arbiter #(
    .NrCommitPorts ( NrCommitPorts )
  ) i_pc_rr_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( pc_empty   ),
    .pc_i       ( pc_head    ),
    .pop_o      ( pc_pop     ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       )
  );

endmodule

//--- testbench/tb_commit_trace.sv
module tb_commit_trace;

  import riscv_types_pkg::*;
  import trace_pkg::*;

  localparam int unsigned NrCommitPorts = 2;
  localparam int unsigned PcQueueDepth  = 16;
  localparam int unsigned NrCycles      = 2000;
  localparam int unsigned DrainTimeout  = 200;
  // Stop acknowledging on a port well before its queue fills
  localparam int unsigned QueueMargin   = PcQueueDepth - 4;

  logic                              clk_i;
  logic                              rst_ni;
  commit_entry_t [NrCommitPorts-1:0] commit_entry;
  logic          [NrCommitPorts-1:0] commit_ack;
  priv_lvl_t                         priv_lvl;
  logic                              rvfi_valid;
  retire_rec_t                       rvfi_rec;
  logic                              rvfi_trap;
  logic                              pc_valid;
  xlen_t                             pc;

  // Stimulus and model state
  logic [31:0]                       lfsr_q;
  logic [29:0]                       pc_serial;
  commit_entry_t [NrCommitPorts-1:0] cur_entry, prev_entry;
  logic          [NrCommitPorts-1:0] cur_ack, prev_ack;
  priv_lvl_t                         cur_priv, prev_priv;
  retire_rec_t                       exp_rec;
  xlen_t                             exp_pc_q [NrCommitPorts][$];
  // Expected round-robin start port of the PC stream
  int unsigned                       exp_rr_ptr;

  commit_trace #(
    .NrCommitPorts ( NrCommitPorts ),
    .PcQueueDepth  ( PcQueueDepth  )
  ) commit_trace_i (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .commit_entry_i ( commit_entry ),
    .commit_ack_i   ( commit_ack   ),
    .priv_lvl_i     ( priv_lvl     ),
    .rvfi_valid_o   ( rvfi_valid   ),
    .rvfi_rec_o     ( rvfi_rec     ),
    .rvfi_trap_o    ( rvfi_trap    ),
    .pc_valid_o     ( pc_valid     ),
    .pc_o           ( pc           )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit
  function automatic logic [63:0] rand_bits(int unsigned n);
    logic [63:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r      = {r[62:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic pending_pcs();
    logic any;
    any = 1'b0;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      if (exp_pc_q[p].size() != 0) begin
        any = 1'b1;
      end
    end
    return any;
  endfunction

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic stop_on_failure();
    $display("Something failed");
    $fatal(1, "Run stopped at %0t", $time);
  endtask

  task automatic compare_bit(string name, logic exp, logic act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_xlen(string name, xlen_t exp, xlen_t act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  task automatic compare_rec(string name, retire_rec_t exp, retire_rec_t act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_on_failure();
    end
  endtask

  // ------------------------------
  // Stimulus, model and checks
  // ------------------------------
  task automatic drive_cycle(bit idle);
    logic [63:0] r;
    logic [63:0] ack_draw;
    logic [63:0] ex_draw;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      r                  = rand_bits(32);
      cur_entry[p].pc    = {r[31:0], pc_serial, 2'b00};
      pc_serial          = pc_serial + 30'd1;
      r                  = rand_bits(32);
      cur_entry[p].insn  = r[31:0];
      r                  = rand_bits(15);
      cur_entry[p].rs1   = r[4:0];
      cur_entry[p].rs2   = r[9:5];
      cur_entry[p].rd    = r[14:10];
      ex_draw            = rand_bits(2);
      cur_entry[p].ex_valid = (ex_draw == '0);
      ack_draw           = rand_bits(2);
      cur_ack[p]         = !idle && (ack_draw == '0) && (exp_pc_q[p].size() < QueueMargin);
    end
    r = rand_bits(2);
    // Reserved encoding 2 folds onto M
    cur_priv = (r[1:0] == 2'b10) ? PRIV_LVL_M : priv_lvl_t'(r[1:0]);
    commit_entry <= cur_entry;
    commit_ack   <= cur_ack;
    priv_lvl     <= cur_priv;
  endtask

  task automatic check_cycle();
    logic  exp_valid;
    logic  exp_trap;
    int    winner;
    int    gnt;
    int    cand;
    xlen_t head;
    exp_valid = 1'b0;
    exp_trap  = 1'b0;
    winner    = -1;
    gnt       = -1;
    for (int unsigned p = 0; p < NrCommitPorts; p++) begin
      if (prev_ack[p] && prev_entry[p].ex_valid) begin
        exp_trap = 1'b1;
      end else if (prev_ack[p]) begin
        exp_pc_q[p].push_back(prev_entry[p].pc);
      end
    end
    // Highest retiring port describes the record
    for (int p = int'(NrCommitPorts) - 1; p >= 0; p--) begin
      if (winner < 0 && prev_ack[p] && !prev_entry[p].ex_valid) begin
        winner = p;
      end
    end
    if (winner >= 0) begin
      exp_valid        = 1'b1;
      exp_rec.order    = exp_rec.order + 64'd1;
      exp_rec.insn     = prev_entry[winner].insn;
      exp_rec.pc_rdata = prev_entry[winner].pc;
      exp_rec.pc_wdata = prev_entry[winner].pc + 64'd4;
      exp_rec.rs1_addr = prev_entry[winner].rs1;
      exp_rec.rs2_addr = prev_entry[winner].rs2;
      exp_rec.rd_addr  = prev_entry[winner].rd;
      exp_rec.mode     = prev_priv;
    end
    compare_bit("rvfi_valid_o", exp_valid, rvfi_valid);
    compare_bit("rvfi_trap_o", exp_trap, rvfi_trap);
    compare_rec("rvfi_rec_o", exp_rec, rvfi_rec);
    compare_bit("pc_valid_o", pending_pcs(), pc_valid);
    if (pc_valid) begin
      // First non-empty port at or after the expected pointer
      for (int k = 0; k < int'(NrCommitPorts); k++) begin
        cand = (int'(exp_rr_ptr) + k) % int'(NrCommitPorts);
        if (gnt < 0 && exp_pc_q[cand].size() != 0) begin
          gnt = cand;
        end
      end
      head = exp_pc_q[gnt].pop_front();
      compare_xlen("pc_o", head, pc);
      exp_rr_ptr = (gnt + 1) % int'(NrCommitPorts);
    end
  endtask

  task automatic run_cycle(bit idle);
    @(posedge clk_i);
    drive_cycle(idle);
    // Outputs are settled by the falling edge
    @(negedge clk_i);
    check_cycle();
    prev_entry = cur_entry;
    prev_ack   = cur_ack;
    prev_priv  = cur_priv;
  endtask

  initial begin : stimulus
    int unsigned waited;
    rst_ni       = 1'b0;
    commit_entry = '0;
    commit_ack   = '0;
    priv_lvl     = PRIV_LVL_M;
    lfsr_q       = 32'he97d_4ef4;
    pc_serial    = '0;
    cur_entry    = '0;
    cur_ack      = '0;
    cur_priv     = PRIV_LVL_M;
    prev_entry   = '0;
    prev_ack     = '0;
    prev_priv    = PRIV_LVL_M;
    exp_rec      = '0;
    exp_rr_ptr   = 0;
    waited       = 0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    // Quiet cycles with all outputs low
    repeat (8) run_cycle(1'b1);
    repeat (NrCycles) run_cycle(1'b0);

    // Flush the last commits into the model, then drain the stream
    repeat (2) run_cycle(1'b1);
    while (pending_pcs() && waited < DrainTimeout) begin
      run_cycle(1'b1);
      waited++;
    end
    if (pending_pcs()) begin
      $display("Timeout: retired PCs still missing from the PC stream after draining");
      stop_on_failure();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

//--- vlog.f
hw/riscv_types_pkg.sv
hw/trace_pkg.sv
hw/pc_queue.sv
hw/pc_rr_arbiter.sv
hw/retire_reporter.sv
hw/commit_trace.sv
testbench/tb_commit_trace.sv

//--- Bender.yml
package:
  name: commit_trace

sources:
  # Packages first, then the RTL in dependency order
  - files:
      - hw/riscv_types_pkg.sv
      - hw/trace_pkg.sv
      - hw/pc_queue.sv
      - hw/pc_rr_arbiter.sv
      - hw/retire_reporter.sv
      - hw/commit_trace.sv

  - target: test
    files:
      - testbench/tb_commit_trace.sv
